//--- build.f
+incdir+include
hw/scrypt_pkg.sv
hw/salsa_core.sv
hw/block_mix.sv
hw/scratchpad.sv
hw/romix_ctrl.sv
hw/romix_top.sv
verif/tb_clock.sv
verif/romix_tb.sv

//--- Bender.yml
package:
  name: scrypt_romix

sources:
  - hw/scrypt_pkg.sv
  - hw/salsa_core.sv
  - hw/block_mix.sv
  - hw/scratchpad.sv
  - hw/romix_ctrl.sv
  - hw/romix_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_clock.sv
      - verif/romix_tb.sv

//--- include/romix_model.svh
`ifndef romix_model_svh
`define romix_model_svh

// Reference scrypt ROMix with r = 1, included inside the testbench module
// Expects a localparam depth in the including scope

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [31:0] rotl32(input logic [31:0] v, input int n);
	rotl32 = (v << n) | (v >> (32 - n));
endfunction

// Quarter round on y0..y3, result packed as {z3, z2, z1, z0}
function automatic logic [127:0] quarter_round(input logic [31:0] y0, input logic [31:0] y1,
		input logic [31:0] y2, input logic [31:0] y3);
	logic [31:0] z0;
	logic [31:0] z1;
	logic [31:0] z2;
	logic [31:0] z3;
	z1 = y1 ^ rotl32(y0 + y3, 7);
	z2 = y2 ^ rotl32(z1 + y0, 9);
	z3 = y3 ^ rotl32(z2 + z1, 13);
	z0 = y0 ^ rotl32(z3 + z2, 18);
	quarter_round = {z3, z2, z1, z0};
endfunction

// Salsa20/8 core with the final add of the input
function automatic logic [511:0] salsa20_8(input logic [511:0] b);
	logic [31:0] x [16];
	logic [127:0] q;
	int idx [4];
	int dr;
	int half;
	int i;
	int j;
	for (i = 0; i < 16; i++) begin
		x[i] = b[32*i +: 32];
	end
	for (dr = 0; dr < 4; dr++) begin   // Four double rounds
		for (half = 0; half < 2; half++) begin
			for (i = 0; i < 4; i++) begin
				for (j = 0; j < 4; j++) begin
					if (half == 0)
						idx[j] = (5 * i + 4 * j) % 16;   // Column i, down from the diagonal
					else
						idx[j] = 4 * i + (i + j) % 4;    // Row i, right of the diagonal
				end
				q = quarter_round(x[idx[0]], x[idx[1]], x[idx[2]], x[idx[3]]);
				for (j = 0; j < 4; j++) begin
					x[idx[j]] = q[32*j +: 32];
				end
			end
		end
	end
	for (i = 0; i < 16; i++) begin
		salsa20_8[32*i +: 32] = x[i] + b[32*i +: 32];
	end
endfunction

// BlockMix, r = 1, new low half in the low bits
function automatic logic [1023:0] block_mix_ref(input logic [1023:0] b);
	logic [511:0] y0;
	logic [511:0] y1;
	y0 = salsa20_8(b[511:0] ^ b[1023:512]);
	y1 = salsa20_8(y0 ^ b[1023:512]);
	block_mix_ref = {y1, y0};
endfunction

function automatic logic [1023:0] romix_ref(input logic [1023:0] b);
	logic [1023:0] v [depth];
	logic [1023:0] x;
	int i;
	int j;
	x = b;
	for (i = 0; i < depth; i++) begin
		v[i] = x;
		x = block_mix_ref(x);
	end
	for (i = 0; i < depth; i++) begin
		j = int'(x[512 +: 32] % 32'(depth));   // Integerify on word 16
		x = block_mix_ref(x ^ v[j]);
	end
	romix_ref = x;
endfunction

`endif

//--- verif/romix_tb.sv
`timescale 1ns/1ps

module romix_tb;
	import scrypt_pkg::*;

	localparam int addr_bits = 4;
	localparam int depth = 2 ** addr_bits;   // Scratchpad entries for the DUT and the model
	localparam int wait_limit = 4000;        // Cycles allowed per wait

	logic hash_clk;
	logic reset;
	logic block_ready;
	logic [x_w-1:0] block_in;
	logic block_taken;
	logic [nonce_w-1:0] nonce_start;
	logic nonce_load;
	logic mix_done;
	logic [x_w-1:0] mix_out;
	logic [nonce_w-1:0] nonce_out;
	logic busy;

	logic [31:0] lfsr_q;
	logic [x_w-1:0] blocks [$];   // Blocks of the next run
	int errors;
	int tests_run;
	int tests_ok;
	int blocks_sent;
	logic timed_out;

	// Monitor state
	logic prev_taken;
	logic prev_done;
	logic pending;                // Block taken and its result not yet out
	logic seen_done;
	logic [x_w-1:0] held_out;
	logic [nonce_w-1:0] held_nonce;
	int taken_count;
	int done_count;

	`include "romix_model.svh"

	tb_clock #(.period_ns(40), .reset_cycles(5)) clk0 (.hash_clk(hash_clk), .reset(reset));

	romix_top #(
		.addr_bits (addr_bits)
	) dut0 (
		.hash_clk    (hash_clk),
		.reset       (reset),
		.block_ready (block_ready),
		.block_in    (block_in),
		.block_taken (block_taken),
		.nonce_start (nonce_start),
		.nonce_load  (nonce_load),
		.mix_done    (mix_done),
		.mix_out     (mix_out),
		.nonce_out   (nonce_out),
		.busy        (busy)
	);

	task automatic log_error(input string msg);
		errors++;
		$display("Error at %0t ns: %s", $time, msg);
	endtask

	task automatic fill_random(output logic [x_w-1:0] v);
		int i;
		for (i = 0; i < x_w; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v[i] = lfsr_q[0];   // One step per bit
		end
	endtask

	task automatic wait_reset();
		int cycles;
		cycles = 0;
		do begin
			@(posedge hash_clk);
			cycles++;
		end while (reset && cycles < wait_limit);
		if (reset) begin
			timed_out = 1'b1;
			$display("Timed out: reset was never released");
		end
	endtask

	// Looks at the current edge first since the take can share an edge with mix_done
	task automatic wait_taken();
		int cycles;
		cycles = 0;
		while (!block_taken && !timed_out && cycles < wait_limit) begin
			@(posedge hash_clk);
			cycles++;
		end
		if (!block_taken && !timed_out) begin
			timed_out = 1'b1;
			$display("Timed out: block_taken did not come within %0d cycles", wait_limit);
		end
	endtask

	task automatic wait_done();
		int cycles;
		cycles = 0;
		if (!timed_out) begin
			do begin
				@(posedge hash_clk);
				cycles++;
			end while (!mix_done && cycles < wait_limit);
			if (!mix_done) begin
				timed_out = 1'b1;
				$display("Timed out: mix_done did not come within %0d cycles", wait_limit);
			end
		end
	endtask

	// Sends the queued blocks back to back with block_ready held
	task automatic run_blocks(input logic [nonce_w-1:0] first_nonce);
		int k;
		logic [x_w-1:0] expect_out;
		logic [nonce_w-1:0] expect_nonce;
		k = 0;
		block_in <= blocks[0];
		block_ready <= 1'b1;
		while (k < blocks.size() && !timed_out) begin
			wait_taken();
			if (!timed_out) begin
				blocks_sent++;
				if (k + 1 < blocks.size())
					block_in <= blocks[k + 1];   // Next one waits for S_IDLE
				else
					block_ready <= 1'b0;
				expect_out = romix_ref(blocks[k]);
				expect_nonce = first_nonce + nonce_w'(k);
				wait_done();
			end
			if (!timed_out) begin
				assert (mix_out == expect_out)
				else log_error($sformatf("mix_out of block %0d differs from the model", k));
				assert (nonce_out == expect_nonce)
				else log_error($sformatf("nonce_out %h, expected %h", nonce_out, expect_nonce));
			end
			k++;
		end
		@(posedge hash_clk);   // Monitor catches up
	endtask

	task automatic finish_test(input string name, input int base);
		tests_run++;
		if (errors == base && !timed_out) begin
			tests_ok++;
			$display("%s: PASS", name);
		end else begin
			$display("%s: FAIL", name);
		end
	endtask

	// Pulse and hold rules on every edge out of reset
	always @(posedge hash_clk) begin
		if (reset) begin
			prev_taken = 1'b0;
			prev_done = 1'b0;
			pending = 1'b0;
			seen_done = 1'b0;
			taken_count = 0;
			done_count = 0;
		end else begin
			assert (!(block_taken && !block_ready))
			else log_error("block_taken without block_ready");
			assert (!(block_taken && prev_taken))
			else log_error("block_taken longer than one cycle");
			assert (!(mix_done && prev_done))
			else log_error("mix_done longer than one cycle");
			// High from the take until the result comes out
			assert (busy == (pending && !mix_done))
			else log_error("busy does not follow the block in flight");
			if (mix_done) begin
				assert (pending) else log_error("mix_done with no block in flight");
				pending = 1'b0;
				seen_done = 1'b1;
				held_out = mix_out;
				held_nonce = nonce_out;
				done_count++;
			end else if (seen_done) begin
				assert (mix_out == held_out && nonce_out == held_nonce)
				else log_error("mix_out or nonce_out changed between mix_done pulses");
			end
			if (block_taken) begin
				assert (!pending) else log_error("second block_taken before mix_done");
				pending = 1'b1;
				taken_count++;
			end
			prev_taken = block_taken;
			prev_done = mix_done;
		end
	end

	initial begin
		logic [x_w-1:0] blk;
		int i;
		int base;
		block_ready = 1'b0;
		block_in = '0;
		nonce_start = '0;   // Differs from the all ones after reset and loads 0
		nonce_load = 1'b0;
		lfsr_q = 32'hce8c_8545;
		errors = 0;
		tests_run = 0;
		tests_ok = 0;
		blocks_sent = 0;
		timed_out = 1'b0;
		wait_reset();

		base = errors;
		for (i = 0; i < 20; i++) begin
			@(posedge hash_clk);
			assert (!mix_done && !block_taken && !busy)
			else log_error("output active while idle after reset");
		end
		finish_test("test 1 idle after reset", base);

		base = errors;
		for (i = 0; i < 32; i++) begin
			blk[32*i +: 32] = 32'h0302_0100 + i * 32'h0404_0404;   // Counting bytes
		end
		blocks.delete();
		blocks.push_back(blk);
		run_blocks(nonce_w'(0));
		finish_test("test 2 fixed vector", base);

		base = errors;
		blocks.delete();
		for (i = 0; i < 3; i++) begin
			fill_random(blk);
			blocks.push_back(blk);
		end
		run_blocks(nonce_w'(1));
		finish_test("test 3 random blocks", base);

		base = errors;
		@(posedge hash_clk);
		assert (taken_count == blocks_sent && done_count == blocks_sent)
		else log_error($sformatf("%0d takes and %0d results for %0d blocks",
			taken_count, done_count, blocks_sent));
		finish_test("test 4 pulse rules", base);

		// Load near the top so the count wraps
		base = errors;
		nonce_start <= 32'hffff_fffe;
		nonce_load <= 1'b1;
		@(posedge hash_clk);
		nonce_load <= 1'b0;
		blocks.delete();
		for (i = 0; i < 3; i++) begin
			fill_random(blk);
			blocks.push_back(blk);
		end
		run_blocks(32'hffff_fffe);
		nonce_load <= 1'b1;   // Same value again so only the strobe reloads
		@(posedge hash_clk);
		nonce_load <= 1'b0;
		blocks.delete();
		fill_random(blk);
		blocks.push_back(blk);
		run_blocks(32'hffff_fffe);
		finish_test("test 5 nonce load and increment", base);

		base = errors;
		nonce_start <= 32'h1234_5678;   // No strobe
		@(posedge hash_clk);
		blocks.delete();
		fill_random(blk);
		blocks.push_back(blk);
		run_blocks(32'h1234_5678);
		finish_test("test 6 nonce reload on change", base);

		$display("summary: %0d of %0d tests ok, %0d errors", tests_ok, tests_run, errors);
		if (timed_out)
			$display("run stopped early on a timeout");
		if (errors == 0 && !timed_out && tests_ok == tests_run) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

//--- verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int period_ns = 40,
	parameter int reset_cycles = 5
) (
	output logic hash_clk,
	output logic reset
);

	initial begin
		hash_clk = 1'b0;
		forever #(period_ns / 2) hash_clk = ~hash_clk;   // Free running
	end

	// Synchronous reset, dropped on a rising edge
	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge hash_clk);
		reset <= 1'b0;
	end

endmodule

//--- hw/romix_top.sv
`timescale 1ns/1ps

module romix_top #(
	parameter int addr_bits = 10
) (
	input  logic                           hash_clk,
	input  logic                           reset,
	input  logic                           block_ready,
	input  logic [scrypt_pkg::x_w-1:0]     block_in,
	output logic                           block_taken,
	input  logic [scrypt_pkg::nonce_w-1:0] nonce_start,
	input  logic                           nonce_load,
	output logic                           mix_done,
	output logic [scrypt_pkg::x_w-1:0]     mix_out,
	output logic [scrypt_pkg::nonce_w-1:0] nonce_out,
	output logic                           busy
);
	import scrypt_pkg::*;

	// Controller to BlockMix
	logic bm_start;
	logic [x_w-1:0] bm_in;
	logic bm_done;
	logic [x_w-1:0] bm_out;

	// Controller to scratchpad
	logic sp_we;
	logic [addr_bits-1:0] sp_addr;
	logic [x_w-1:0] sp_wr_data;
	logic [x_w-1:0] sp_rd_data;

	romix_ctrl #(
		.addr_bits (addr_bits)
	) ctrl0 (
		.hash_clk    (hash_clk),
		.reset       (reset),
		.block_ready (block_ready),
		.block_in    (block_in),
		.block_taken (block_taken),
		.nonce_start (nonce_start),
		.nonce_load  (nonce_load),
		.bm_start    (bm_start),
		.bm_in       (bm_in),
		.bm_done     (bm_done),
		.bm_out      (bm_out),
		.sp_we       (sp_we),
		.sp_addr     (sp_addr),
		.sp_wr_data  (sp_wr_data),
		.sp_rd_data  (sp_rd_data),
		.mix_done    (mix_done),
		.mix_out     (mix_out),
		.nonce_out   (nonce_out),
		.busy        (busy)
	);

	block_mix bm0 (
		.hash_clk (hash_clk),
		.reset    (reset),
		.bm_start (bm_start),
		.bm_in    (bm_in),
		.bm_done  (bm_done),
		.bm_out   (bm_out)
	);

	scratchpad #(
		.addr_bits (addr_bits)
	) sp0 (
		.hash_clk (hash_clk),
		.we       (sp_we),
		.addr     (sp_addr),
		.wr_data  (sp_wr_data),
		.rd_data  (sp_rd_data)
	);

endmodule

//--- hw/romix_ctrl.sv
`timescale 1ns/1ps

module romix_ctrl #(
	parameter int addr_bits = 10
) (
	input  logic                           hash_clk,
	input  logic                           reset,
	input  logic                           block_ready,
	input  logic [scrypt_pkg::x_w-1:0]     block_in,
	output logic                           block_taken,
	input  logic [scrypt_pkg::nonce_w-1:0] nonce_start,
	input  logic                           nonce_load,
	output logic                           bm_start,
	output logic [scrypt_pkg::x_w-1:0]     bm_in,
	input  logic                           bm_done,
	input  logic [scrypt_pkg::x_w-1:0]     bm_out,
	output logic                           sp_we,
	output logic [addr_bits-1:0]           sp_addr,
	output logic [scrypt_pkg::x_w-1:0]     sp_wr_data,
	input  logic [scrypt_pkg::x_w-1:0]     sp_rd_data,
	output logic                           mix_done,
	output logic [scrypt_pkg::x_w-1:0]     mix_out,
	output logic [scrypt_pkg::nonce_w-1:0] nonce_out,
	output logic                           busy
);
	import scrypt_pkg::*;

	romix_state_e state_q;
	logic [x_w-1:0] x_q;                // Working block X
	logic [addr_bits-1:0] addr_q;       // Write counter, later the Integerify address
	logic [addr_bits-1:0] mix_cnt_q;    // Mix iterations done
	logic xor_pend_q;                   // Next S_MIX cycle folds in the entry
	logic take;
	logic mix_xor;
	logic mix_last;
	logic [nonce_w-1:0] nonce_cnt_q;
	logic [nonce_w-1:0] nonce_prev_q;   // Last loaded start value
	logic [nonce_w-1:0] nonce_1_q;      // Nonce of the block in flight

	assign take = (state_q == S_IDLE) && block_ready;
	assign block_taken = take;   // Clears the source's ready level
	assign busy = (state_q != S_IDLE);
	assign mix_xor = (state_q == S_MIX) && xor_pend_q;
	assign mix_last = (state_q == S_MIX) && !xor_pend_q && bm_done && (mix_cnt_q == '1);

	assign bm_in = x_q;
	assign sp_wr_data = x_q;
	assign sp_addr = addr_q;

	always_ff @(posedge hash_clk) begin
		if (reset) begin
			state_q <= S_IDLE;
			addr_q <= '0;
			mix_cnt_q <= '0;
			xor_pend_q <= 1'b0;
			bm_start <= 1'b0;
			sp_we <= 1'b0;
			mix_done <= 1'b0;
		end else begin
			bm_start <= 1'b0;
			sp_we <= 1'b0;
			mix_done <= 1'b0;
			case (state_q)
				S_IDLE: begin
					if (take) begin
						addr_q <= '0;
						mix_cnt_q <= '0;
						bm_start <= 1'b1;
						sp_we <= 1'b1;   // Store X while it is mixed
						state_q <= S_WRITE;
					end
				end
				S_WRITE: begin
					if (bm_done) begin
						if (addr_q == '1) begin
							state_q <= S_READ;   // Scratchpad full
						end else begin
							addr_q <= addr_q + 1'b1;
							bm_start <= 1'b1;
							sp_we <= 1'b1;
						end
					end
				end
				S_READ: begin
					// Integerify, modulo depth
					addr_q <= x_q[integerify_word*word_w +: addr_bits];
					xor_pend_q <= 1'b1;
					state_q <= S_MIX;
				end
				S_MIX: begin
					if (xor_pend_q) begin
						xor_pend_q <= 1'b0;
						bm_start <= 1'b1;   // Mix the XORed block
					end else if (bm_done) begin
						mix_cnt_q <= mix_cnt_q + 1'b1;
						if (mix_last) begin
							mix_done <= 1'b1;
							state_q <= S_IDLE;
						end else begin
							state_q <= S_READ;
						end
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge hash_clk) begin
		if (take)
			x_q <= block_in;
		else if (mix_xor)
			x_q <= x_q ^ sp_rd_data;
		else if (bm_done)
			x_q <= bm_out;
		if (take)
			nonce_1_q <= nonce_cnt_q;   // Pipeline stage one
		if (mix_last) begin
			mix_out <= bm_out;
			nonce_out <= nonce_1_q;     // Stage two, paired with its result
		end
	end

	// Nonce counter, load on strobe or on a new start value
	always_ff @(posedge hash_clk) begin
		if (reset) begin
			nonce_cnt_q <= '0;
			nonce_prev_q <= '1;
		end else if (nonce_load || (nonce_start != nonce_prev_q)) begin
			nonce_cnt_q <= nonce_start;   // Load beats increment
			nonce_prev_q <= nonce_start;
		end else if (take) begin
			nonce_cnt_q <= nonce_cnt_q + 1'b1;
		end
	end

endmodule

//--- hw/scratchpad.sv
`timescale 1ns/1ps

module scratchpad #(
	parameter int addr_bits = 10
) (
	input  logic                       hash_clk,
	input  logic                       we,
	input  logic [addr_bits-1:0]       addr,
	input  logic [scrypt_pkg::x_w-1:0] wr_data,
	output logic [scrypt_pkg::x_w-1:0] rd_data
);
	import scrypt_pkg::*;

	localparam int depth = 2 ** addr_bits;

	logic [x_w-1:0] mem [depth];   // One full block per entry

	// Write on the clock edge
	always_ff @(posedge hash_clk) begin
		if (we)
			mem[addr] <= wr_data;
	end

	assign rd_data = mem[addr];   // Unregistered read, old data during a write

endmodule

//--- hw/block_mix.sv
`timescale 1ns/1ps

module block_mix (
	input  logic                       hash_clk,
	input  logic                       reset,
	input  logic                       bm_start,
	input  logic [scrypt_pkg::x_w-1:0] bm_in,
	output logic                       bm_done,
	output logic [scrypt_pkg::x_w-1:0] bm_out
);
	import scrypt_pkg::*;

	bm_state_e state_q;
	logic second_go_q;             // Launch of the second Salsa call
	logic first_go;
	logic [block_w-1:0] hi_q;      // Old high half
	logic [block_w-1:0] lo_q;      // New low half
	logic salsa_start;
	logic [block_w-1:0] salsa_in;
	logic salsa_done;
	logic [block_w-1:0] salsa_out;

	assign first_go = (state_q == BM_IDLE) && bm_start;   // Busy core ignores start
	assign salsa_start = first_go || second_go_q;

	// Second call takes new low ^ old high
	assign salsa_in = second_go_q ? (lo_q ^ hi_q) :
		(bm_in[block_w-1:0] ^ bm_in[x_w-1:block_w]);

	salsa_core salsa0 (
		.hash_clk  (hash_clk),
		.reset     (reset),
		.start     (salsa_start),
		.salsa_in  (salsa_in),
		.done      (salsa_done),
		.salsa_out (salsa_out)
	);

	always_ff @(posedge hash_clk) begin
		if (reset) begin
			state_q <= BM_IDLE;
			second_go_q <= 1'b0;
			bm_done <= 1'b0;
		end else begin
			second_go_q <= 1'b0;
			bm_done <= 1'b0;
			case (state_q)
				BM_IDLE: begin
					if (bm_start)
						state_q <= BM_FIRST;
				end
				BM_FIRST: begin
					if (salsa_done) begin
						second_go_q <= 1'b1;   // One cycle gap for the XOR
						state_q <= BM_SECOND;
					end
				end
				BM_SECOND: begin
					if (salsa_done) begin
						bm_done <= 1'b1;
						state_q <= BM_IDLE;
					end
				end
				default: state_q <= BM_IDLE;
			endcase
		end
	end

	always_ff @(posedge hash_clk) begin
		if (first_go)
			hi_q <= bm_in[x_w-1:block_w];
		if (state_q == BM_FIRST && salsa_done)
			lo_q <= salsa_out;
		if (state_q == BM_SECOND && salsa_done)
			bm_out <= {salsa_out, lo_q};   // New high over new low
	end

endmodule

//--- hw/salsa_core.sv
`timescale 1ns/1ps

module salsa_core (
	input  logic                           hash_clk,
	input  logic                           reset,
	input  logic                           start,
	input  logic [scrypt_pkg::block_w-1:0] salsa_in,
	output logic                           done,
	output logic [scrypt_pkg::block_w-1:0] salsa_out
);
	import scrypt_pkg::*;

	localparam int n_words = block_w / word_w;
	localparam int passes = salsa_rounds / rounds_per_cycle;   // Clocks of rounds
	localparam int cnt_w = $clog2(passes);

	logic [block_w-1:0] x_q;      // Working state
	logic [block_w-1:0] orig_q;   // Input copy for the feed-forward add
	logic [block_w-1:0] dr_in;
	logic [block_w-1:0] dr_out;
	logic [block_w-1:0] sum;
	logic [cnt_w-1:0] cnt_q;
	logic busy_q;
	logic last_pass;

	function automatic logic [word_w-1:0] rotl(input logic [word_w-1:0] v, input int n);
		rotl = (v << n) | (v >> (word_w - n));
	endfunction

	// Even rounds work on columns, odd rounds on rows
	function automatic logic [block_w-1:0] salsa_pass(input logic [block_w-1:0] s);
		logic [word_w-1:0] w [n_words];
		int a;
		int b;
		int c;
		int d;
		for (int i = 0; i < n_words; i++) begin
			w[i] = s[i*word_w +: word_w];
		end
		for (int r = 0; r < rounds_per_cycle; r++) begin
			for (int q = 0; q < 4; q++) begin
				a = (r % 2 == 1) ? row_idx[4*q] : col_idx[4*q];
				b = (r % 2 == 1) ? row_idx[4*q+1] : col_idx[4*q+1];
				c = (r % 2 == 1) ? row_idx[4*q+2] : col_idx[4*q+2];
				d = (r % 2 == 1) ? row_idx[4*q+3] : col_idx[4*q+3];
				w[b] = w[b] ^ rotl(w[a] + w[d], salsa_rot[0]);
				w[c] = w[c] ^ rotl(w[b] + w[a], salsa_rot[1]);
				w[d] = w[d] ^ rotl(w[c] + w[b], salsa_rot[2]);
				w[a] = w[a] ^ rotl(w[d] + w[c], salsa_rot[3]);
			end
		end
		for (int i = 0; i < n_words; i++) begin
			salsa_pass[i*word_w +: word_w] = w[i];
		end
	endfunction

	assign dr_in = busy_q ? x_q : salsa_in;   // First pass straight off the input
	assign dr_out = salsa_pass(dr_in);
	assign last_pass = busy_q && (cnt_q == cnt_w'(salsa_latency - 1));
	assign salsa_out = x_q;

	// Feed-forward add, word by word
	always_comb begin
		for (int i = 0; i < n_words; i++) begin
			sum[i*word_w +: word_w] = dr_out[i*word_w +: word_w] + orig_q[i*word_w +: word_w];
		end
	end

	always_ff @(posedge hash_clk) begin
		if (reset) begin
			busy_q <= 1'b0;
			cnt_q <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (!busy_q) begin
				if (start) begin
					busy_q <= 1'b1;
					cnt_q <= cnt_w'(1);   // One pass done on the start edge
				end
			end else begin
				cnt_q <= cnt_q + 1'b1;
				if (last_pass) begin
					busy_q <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge hash_clk) begin
		if (!busy_q && start) begin
			orig_q <= salsa_in;
			x_q <= dr_out;
		end else if (busy_q) begin
			x_q <= last_pass ? sum : dr_out;   // Holds result until next start
		end
	end

endmodule

//--- hw/scrypt_pkg.sv
package scrypt_pkg;

	localparam int word_w = 32;            // Salsa word
	localparam int block_w = 512;          // Half scrypt block, sixteen words
	localparam int x_w = 1024;             // Full scrypt block
	localparam int salsa_rounds = 8;       // Salsa20/8
	localparam int rounds_per_cycle = 2;   // Column round plus row round each clock
	localparam int salsa_latency = 4;      // salsa_core start to done
	localparam int bm_latency = 10;        // block_mix start to done, 4 + 1 + 4 + 1
	localparam int integerify_word = 16;   // First word of the high half
	localparam int nonce_w = 32;

	// Rotate amounts for the four steps of a quarter round
	localparam int salsa_rot [4] = '{7, 9, 13, 18};

	// Word order a, b, c, d for each of the four quarter rounds
	localparam int col_idx [16] = '{0, 4, 8, 12, 5, 9, 13, 1, 10, 14, 2, 6, 15, 3, 7, 11};
	localparam int row_idx [16] = '{0, 1, 2, 3, 5, 6, 7, 4, 10, 11, 8, 9, 15, 12, 13, 14};

	// ROMix controller
	typedef enum logic [1:0] {
		S_IDLE  = 2'd0,   // Waiting for a block
		S_WRITE = 2'd1,   // Filling the scratchpad
		S_READ  = 2'd2,   // Integerify address into the RAM
		S_MIX   = 2'd3    // XOR with entry, then BlockMix
	} romix_state_e;

	// BlockMix sequencer
	typedef enum logic [1:0] {
		BM_IDLE   = 2'd0,
		BM_FIRST  = 2'd1,  // Salsa on low ^ high
		BM_SECOND = 2'd2   // Salsa on new low ^ old high
	} bm_state_e;

endpackage
